// ==== verilog/vertex_settings.svh ====
// sizing macros; CACHELINE_VERTICES must stay a power of two that fits in lane_count_t
`ifndef VERTEX_SETTINGS_SVH
`define VERTEX_SETTINGS_SVH

// vertices per cacheline, also the chunk size of the walk
`define CACHELINE_VERTICES 8

// width of one vertex field
`define VERTEX_BITS 32

// byte address width
`define ADDRESS_BITS 32

// vertex counts and ids
`define COUNT_BITS 16

// queue depths
`define CMD_QUEUE_DEPTH 4
`define JOB_QUEUE_DEPTH 16

`endif

// ==== verilog/graph_pkg.sv ====
// graph data types; lane i of a cacheline sits at bits [i*VERTEX_BITS +: VERTEX_BITS]
`include "vertex_settings.svh"

package graph_pkg;

	// one field of one vertex
	typedef logic [`VERTEX_BITS-1:0] vertex_field_t;

	// byte address into host memory
	typedef logic [`ADDRESS_BITS-1:0] address_t;

	// vertex count and vertex id
	typedef logic [`COUNT_BITS-1:0] vertex_count_t;

	// one returned data line
	typedef logic [`CACHELINE_VERTICES*`VERTEX_BITS-1:0] cacheline_t;

	// valid lanes of a chunk, 0 to CACHELINE_VERTICES
	typedef logic [3:0] lane_count_t;

	// source array of a command or a data line
	typedef enum logic [1:0] {
		ARRAY_OUT_DEGREE = 2'd0,
		ARRAY_AUX_DATA   = 2'd1,
		ARRAY_EDGES_IDX  = 2'd2
	} graph_array_t;

endpackage

// ==== verilog/job_ctrl_pkg.sv ====
// control types; compile after graph_pkg, whose types the records are built from
package job_ctrl_pkg;

	// chunk walk states
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_CHECK_ROOM,
		SEQ_CMD_OUT_DEGREE,
		SEQ_CMD_AUX,
		SEQ_CMD_EDGES_IDX,
		SEQ_WAIT_LINES,
		SEQ_UNPACK
	} seq_state_t;

	// one read command, count gives the valid lanes of the line
	typedef struct packed {
		graph_pkg::address_t     address;
		graph_pkg::graph_array_t tag;
		graph_pkg::lane_count_t  count;
	} read_cmd_t;

	// one vertex job as seen by the consumer
	typedef struct packed {
		graph_pkg::vertex_count_t id;
		graph_pkg::vertex_field_t out_degree;
		graph_pkg::vertex_field_t edges_idx;
		graph_pkg::vertex_field_t data;
	} vertex_job_t;

endpackage

// ==== verilog/unpack_if.sv ====
// chunk unpack handshake; an order with a lane count of zero rewinds the vertex id
interface unpack_if;

	logic                   unpack_start;
	graph_pkg::lane_count_t unpack_count;
	logic                   lines_ready;
	logic                   unpack_done;

	modport sequencer (
		output unpack_start,
		output unpack_count,
		input  lines_ready,
		input  unpack_done
	);

	modport store (
		input  unpack_start,
		input  unpack_count,
		output lines_ready,
		output unpack_done
	);

endinterface

// ==== verilog/sync_fifo.sv ====
// fall-through queue; a push while full or a pop while empty is dropped
module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         push,
	input  logic [WIDTH-1:0]             data_in,
	input  logic                         pop,
	output logic [WIDTH-1:0]             data_out,
	output logic                         empty,
	output logic                         full,
	output logic [$clog2(DEPTH+1)-1:0]   free_slots
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH+1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	assign do_push    = push && !full;
	assign do_pop     = pop && !empty;
	assign empty      = (count == '0);
	assign full       = (count == CNT_BITS'(DEPTH));
	assign free_slots = CNT_BITS'(DEPTH) - count;
	// head shows straight from storage
	assign data_out   = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) push |-> !full);
	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty);

endmodule

// ==== verilog/vertex_read_sequencer.sv ====
// walks the range one chunk at a time; start is ignored while busy
`include "vertex_settings.svh"

module vertex_read_sequencer (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   start,
	input  graph_pkg::vertex_count_t               num_vertices,
	input  graph_pkg::address_t                    out_degree_base,
	input  graph_pkg::address_t                    aux_base,
	input  graph_pkg::address_t                    edges_idx_base,
	input  logic                                   cmd_queue_empty,
	input  logic [$clog2(`JOB_QUEUE_DEPTH+1)-1:0]  job_free_slots,
	output logic                                   busy,
	output logic                                   cmd_push,
	output job_ctrl_pkg::read_cmd_t                cmd,
	unpack_if.sequencer                            unpack
);

	// byte stride between chunks
	localparam int LINE_BYTES = `CACHELINE_VERTICES * `VERTEX_BITS / 8;

	job_ctrl_pkg::seq_state_t state;
	job_ctrl_pkg::seq_state_t next_state;

	graph_pkg::address_t      out_degree_base_q;
	graph_pkg::address_t      aux_base_q;
	graph_pkg::address_t      edges_idx_base_q;
	graph_pkg::vertex_count_t remaining;
	graph_pkg::address_t      offset;
	graph_pkg::lane_count_t   chunk_count;
	logic                     room;

	assign busy = (state != job_ctrl_pkg::SEQ_IDLE);
	// three free command slots and a whole chunk of job slots
	assign room = cmd_queue_empty && (job_free_slots >= `CACHELINE_VERTICES);

	////////////////////////////////////////////////////////////
	// chunk walk
	////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			job_ctrl_pkg::SEQ_IDLE: begin
				if (start && num_vertices != '0)
					next_state = job_ctrl_pkg::SEQ_CHECK_ROOM;
			end
			job_ctrl_pkg::SEQ_CHECK_ROOM: begin
				if (room)
					next_state = job_ctrl_pkg::SEQ_CMD_OUT_DEGREE;
			end
			job_ctrl_pkg::SEQ_CMD_OUT_DEGREE: next_state = job_ctrl_pkg::SEQ_CMD_AUX;
			job_ctrl_pkg::SEQ_CMD_AUX:        next_state = job_ctrl_pkg::SEQ_CMD_EDGES_IDX;
			job_ctrl_pkg::SEQ_CMD_EDGES_IDX:  next_state = job_ctrl_pkg::SEQ_WAIT_LINES;
			job_ctrl_pkg::SEQ_WAIT_LINES: begin
				if (unpack.lines_ready)
					next_state = job_ctrl_pkg::SEQ_UNPACK;
			end
			job_ctrl_pkg::SEQ_UNPACK: begin
				if (unpack.unpack_done)
					next_state = (remaining == '0) ? job_ctrl_pkg::SEQ_IDLE :
						job_ctrl_pkg::SEQ_CHECK_ROOM;
			end
			default: next_state = job_ctrl_pkg::SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= job_ctrl_pkg::SEQ_IDLE;
			remaining   <= '0;
			offset      <= '0;
			chunk_count <= '0;
		end else begin
			state <= next_state;
			if (state == job_ctrl_pkg::SEQ_IDLE && start) begin
				remaining <= num_vertices;
				offset    <= '0;
			end
			// last chunk may be short
			if (state == job_ctrl_pkg::SEQ_CHECK_ROOM && room)
				chunk_count <= (remaining > `CACHELINE_VERTICES) ?
					graph_pkg::lane_count_t'(`CACHELINE_VERTICES) :
					graph_pkg::lane_count_t'(remaining);
			if (state == job_ctrl_pkg::SEQ_CMD_EDGES_IDX) begin
				offset    <= offset + LINE_BYTES;
				remaining <= remaining - chunk_count;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == job_ctrl_pkg::SEQ_IDLE && start) begin
			out_degree_base_q <= out_degree_base;
			aux_base_q        <= aux_base;
			edges_idx_base_q  <= edges_idx_base;
		end
	end

	////////////////////////////////////////////////////////////
	// commands and unpack order
	////////////////////////////////////////////////////////////

	always_comb begin
		cmd_push    = 1'b0;
		cmd.address = out_degree_base_q + offset;
		cmd.tag     = graph_pkg::ARRAY_OUT_DEGREE;
		cmd.count   = chunk_count;
		case (state)
			job_ctrl_pkg::SEQ_CMD_OUT_DEGREE: cmd_push = 1'b1;
			job_ctrl_pkg::SEQ_CMD_AUX: begin
				cmd_push    = 1'b1;
				cmd.address = aux_base_q + offset;
				cmd.tag     = graph_pkg::ARRAY_AUX_DATA;
			end
			job_ctrl_pkg::SEQ_CMD_EDGES_IDX: begin
				cmd_push    = 1'b1;
				cmd.address = edges_idx_base_q + offset;
				cmd.tag     = graph_pkg::ARRAY_EDGES_IDX;
			end
			default: ;
		endcase
	end

	// zero-lane order on start rewinds the store's id
	assign unpack.unpack_start = (state == job_ctrl_pkg::SEQ_IDLE && start) ||
		(state == job_ctrl_pkg::SEQ_WAIT_LINES && unpack.lines_ready);
	assign unpack.unpack_count = (state == job_ctrl_pkg::SEQ_IDLE) ? '0 : chunk_count;

	// a start during a walk must never rewind the store's id
	assert property (@(posedge clock) disable iff (!rstn)
		(start && busy) |-> !(unpack.unpack_start && unpack.unpack_count == '0));

endmodule

// ==== verilog/vertex_line_store.sv ====
// holds one chunk's three lines; lines must not arrive while a chunk is unpacking
`include "vertex_settings.svh"

module vertex_line_store (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    data_valid,
	input  graph_pkg::graph_array_t data_array,
	input  graph_pkg::cacheline_t   data_line,
	output logic                    job_push,
	output job_ctrl_pkg::vertex_job_t job,
	unpack_if.store                 unpack
);

	graph_pkg::cacheline_t    out_degree_line;
	graph_pkg::cacheline_t    aux_line;
	graph_pkg::cacheline_t    edges_idx_line;
	logic                     out_degree_ready;
	logic                     aux_ready;
	logic                     edges_idx_ready;
	logic                     unpacking;
	graph_pkg::lane_count_t   lanes_left;
	graph_pkg::vertex_count_t vertex_id;

	////////////////////////////////////////////////////////////
	// line capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (data_valid) begin
			case (data_array)
				graph_pkg::ARRAY_OUT_DEGREE: out_degree_line <= data_line;
				graph_pkg::ARRAY_AUX_DATA:   aux_line        <= data_line;
				graph_pkg::ARRAY_EDGES_IDX:  edges_idx_line  <= data_line;
				default: ;
			endcase
		end else if (unpacking) begin
			// next lane moves down to lane 0
			out_degree_line <= out_degree_line >> `VERTEX_BITS;
			aux_line        <= aux_line >> `VERTEX_BITS;
			edges_idx_line  <= edges_idx_line >> `VERTEX_BITS;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			out_degree_ready <= 1'b0;
			aux_ready        <= 1'b0;
			edges_idx_ready  <= 1'b0;
		end else if (unpack.unpack_start) begin
			out_degree_ready <= 1'b0;
			aux_ready        <= 1'b0;
			edges_idx_ready  <= 1'b0;
		end else if (data_valid) begin
			case (data_array)
				graph_pkg::ARRAY_OUT_DEGREE: out_degree_ready <= 1'b1;
				graph_pkg::ARRAY_AUX_DATA:   aux_ready        <= 1'b1;
				graph_pkg::ARRAY_EDGES_IDX:  edges_idx_ready  <= 1'b1;
				default: ;
			endcase
		end
	end

	assign unpack.lines_ready = out_degree_ready && aux_ready && edges_idx_ready;

	////////////////////////////////////////////////////////////
	// unpack, one job per cycle
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			unpacking          <= 1'b0;
			lanes_left         <= '0;
			vertex_id          <= '0;
			unpack.unpack_done <= 1'b0;
		end else begin
			unpack.unpack_done <= (unpacking && lanes_left == 4'd1) ||
				(unpack.unpack_start && unpack.unpack_count == '0);
			if (unpack.unpack_start) begin
				lanes_left <= unpack.unpack_count;
				unpacking  <= (unpack.unpack_count != '0);
				// new range
				if (unpack.unpack_count == '0)
					vertex_id <= '0;
			end else if (unpacking) begin
				lanes_left <= lanes_left - 1'b1;
				vertex_id  <= vertex_id + 1'b1;
				if (lanes_left == 4'd1)
					unpacking <= 1'b0;
			end
		end
	end

	assign job_push       = unpacking;
	assign job.id         = vertex_id;
	assign job.out_degree = out_degree_line[`VERTEX_BITS-1:0];
	assign job.edges_idx  = edges_idx_line[`VERTEX_BITS-1:0];
	assign job.data       = aux_line[`VERTEX_BITS-1:0];

	// the sequencer issues no command for the next chunk before unpack_done
	assert property (@(posedge clock) disable iff (!rstn) unpacking |-> !data_valid);

endmodule

// ==== verilog/vertex_job_control.sv ====
// vertex job fetcher top; data lines must return in command grant order
`include "vertex_settings.svh"

module vertex_job_control (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     start,
	input  graph_pkg::vertex_count_t num_vertices,
	input  graph_pkg::address_t      out_degree_base,
	input  graph_pkg::address_t      aux_base,
	input  graph_pkg::address_t      edges_idx_base,
	output logic                     busy,
	output logic                     cmd_request,
	input  logic                     cmd_grant,
	output graph_pkg::address_t      cmd_address,
	output graph_pkg::graph_array_t  cmd_array,
	output graph_pkg::lane_count_t   cmd_count,
	input  logic                     data_valid,
	input  graph_pkg::graph_array_t  data_array,
	input  graph_pkg::cacheline_t    data_line,
	output logic                     job_valid,
	input  logic                     job_request,
	output graph_pkg::vertex_count_t job_id,
	output graph_pkg::vertex_field_t job_out_degree,
	output graph_pkg::vertex_field_t job_edges_idx,
	output graph_pkg::vertex_field_t job_data
);

	job_ctrl_pkg::read_cmd_t               cmd_in;
	job_ctrl_pkg::read_cmd_t               cmd_head;
	logic                                  cmd_push;
	logic                                  cmd_empty;
	job_ctrl_pkg::vertex_job_t             job_in;
	job_ctrl_pkg::vertex_job_t             job_head;
	logic                                  job_push;
	logic                                  job_empty;
	logic [$clog2(`JOB_QUEUE_DEPTH+1)-1:0] job_free_slots;

	unpack_if i_unpack_if ();

	vertex_read_sequencer i_vertex_read_sequencer (
		.clock           (clock),
		.rstn            (rstn),
		.start           (start),
		.num_vertices    (num_vertices),
		.out_degree_base (out_degree_base),
		.aux_base        (aux_base),
		.edges_idx_base  (edges_idx_base),
		.cmd_queue_empty (cmd_empty),
		.job_free_slots  (job_free_slots),
		.busy            (busy),
		.cmd_push        (cmd_push),
		.cmd             (cmd_in),
		.unpack          (i_unpack_if.sequencer)
	);

	vertex_line_store i_vertex_line_store (
		.clock      (clock),
		.rstn       (rstn),
		.data_valid (data_valid),
		.data_array (data_array),
		.data_line  (data_line),
		.job_push   (job_push),
		.job        (job_in),
		.unpack     (i_unpack_if.store)
	);

	// command queue toward the bus
	sync_fifo #(
		.WIDTH ($bits(job_ctrl_pkg::read_cmd_t)),
		.DEPTH (`CMD_QUEUE_DEPTH)
	) i_cmd_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (cmd_push),
		.data_in    (cmd_in),
		.pop        (cmd_grant),
		.data_out   (cmd_head),
		.empty      (cmd_empty),
		.full       (),
		.free_slots ()
	);

	// job queue toward the consumer
	sync_fifo #(
		.WIDTH ($bits(job_ctrl_pkg::vertex_job_t)),
		.DEPTH (`JOB_QUEUE_DEPTH)
	) i_job_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (job_push),
		.data_in    (job_in),
		.pop        (job_request),
		.data_out   (job_head),
		.empty      (job_empty),
		.full       (),
		.free_slots (job_free_slots)
	);

	assign cmd_request    = !cmd_empty;
	assign cmd_address    = cmd_head.address;
	assign cmd_array      = cmd_head.tag;
	assign cmd_count      = cmd_head.count;

	assign job_valid      = !job_empty;
	assign job_id         = job_head.id;
	assign job_out_degree = job_head.out_degree;
	assign job_edges_idx  = job_head.edges_idx;
	assign job_data       = job_head.data;

endmodule

// ==== verif/tb_vertex_job_control.sv ====
// job fetcher testbench; bases are 32-byte aligned and ranges run one after another
`include "vertex_settings.svh"

module tb_vertex_job_control;

	localparam int STEP_LIMIT = 4000;
	localparam int LANE_BYTES = `VERTEX_BITS / 8;
	localparam int LINE_BYTES = `CACHELINE_VERTICES * `VERTEX_BITS / 8;

	logic                     clock;
	logic                     rstn;
	logic                     start;
	graph_pkg::vertex_count_t num_vertices;
	graph_pkg::address_t      out_degree_base;
	graph_pkg::address_t      aux_base;
	graph_pkg::address_t      edges_idx_base;
	logic                     busy;
	logic                     cmd_request;
	logic                     cmd_grant;
	graph_pkg::address_t      cmd_address;
	graph_pkg::graph_array_t  cmd_array;
	graph_pkg::lane_count_t   cmd_count;
	logic                     data_valid;
	graph_pkg::graph_array_t  data_array;
	graph_pkg::cacheline_t    data_line;
	logic                     job_valid;
	logic                     job_request;
	graph_pkg::vertex_count_t job_id;
	graph_pkg::vertex_field_t job_out_degree;
	graph_pkg::vertex_field_t job_edges_idx;
	graph_pkg::vertex_field_t job_data;

	integer seed;
	int     error_count;
	int     check_count;
	int     timeout_count;
	string  test_name;
	int     grant_pct;
	int     consume_pct;
	logic   consume_enable;
	int     lanes_requested;
	int     jobs_popped;
	int     cmd_index;
	int     job_index;

	job_ctrl_pkg::read_cmd_t   exp_cmds[$];
	job_ctrl_pkg::vertex_job_t exp_jobs[$];
	job_ctrl_pkg::read_cmd_t   got_cmds[$];
	job_ctrl_pkg::vertex_job_t got_jobs[$];
	job_ctrl_pkg::read_cmd_t   granted[$];

	vertex_job_control i_vertex_job_control (
		.clock           (clock),
		.rstn            (rstn),
		.start           (start),
		.num_vertices    (num_vertices),
		.out_degree_base (out_degree_base),
		.aux_base        (aux_base),
		.edges_idx_base  (edges_idx_base),
		.busy            (busy),
		.cmd_request     (cmd_request),
		.cmd_grant       (cmd_grant),
		.cmd_address     (cmd_address),
		.cmd_array       (cmd_array),
		.cmd_count       (cmd_count),
		.data_valid      (data_valid),
		.data_array      (data_array),
		.data_line       (data_line),
		.job_valid       (job_valid),
		.job_request     (job_request),
		.job_id          (job_id),
		.job_out_degree  (job_out_degree),
		.job_edges_idx   (job_edges_idx),
		.job_data        (job_data)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// memory contents and expected results
	////////////////////////////////////////////////////////////

	// every element address gets its own word
	function automatic graph_pkg::vertex_field_t mem_word(input graph_pkg::address_t address);
		logic [31:0] mixed;
		mixed = address * 32'h9e37_79b1;
		mixed = mixed ^ (mixed >> 15) ^ {address[7:0], address[31:8]};
		return mixed;
	endfunction

	function automatic void build_expected(input int n, input graph_pkg::address_t od,
		input graph_pkg::address_t aux, input graph_pkg::address_t ei);
		job_ctrl_pkg::read_cmd_t   cmd;
		job_ctrl_pkg::vertex_job_t job;
		int                        lanes;
		int                        elem;
		for (int k = 0; k * `CACHELINE_VERTICES < n; k++) begin
			lanes = n - k * `CACHELINE_VERTICES;
			if (lanes > `CACHELINE_VERTICES)
				lanes = `CACHELINE_VERTICES;
			cmd.count   = graph_pkg::lane_count_t'(lanes);
			cmd.address = od + k * LINE_BYTES;
			cmd.tag     = graph_pkg::ARRAY_OUT_DEGREE;
			exp_cmds.push_back(cmd);
			cmd.address = aux + k * LINE_BYTES;
			cmd.tag     = graph_pkg::ARRAY_AUX_DATA;
			exp_cmds.push_back(cmd);
			cmd.address = ei + k * LINE_BYTES;
			cmd.tag     = graph_pkg::ARRAY_EDGES_IDX;
			exp_cmds.push_back(cmd);
		end
		for (int v = 0; v < n; v++) begin
			// lane v mod 8 of the line that holds chunk v / 8
			elem           = (v / `CACHELINE_VERTICES) * LINE_BYTES +
				(v % `CACHELINE_VERTICES) * LANE_BYTES;
			job.id         = graph_pkg::vertex_count_t'(v);
			job.out_degree = mem_word(od + elem);
			job.edges_idx  = mem_word(ei + elem);
			job.data       = mem_word(aux + elem);
			exp_jobs.push_back(job);
		end
	endfunction

	task automatic check_equal(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("ERR %s expected %h actual %h", what, expected, actual);
		end
	endtask

	task automatic report_problem(input string msg);
		error_count++;
		$display("%s", msg);
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	////////////////////////////////////////////////////////////
	// memory responder and job consumer
	////////////////////////////////////////////////////////////

	initial begin : responder
		int                        delay;
		job_ctrl_pkg::read_cmd_t   cmd;
		job_ctrl_pkg::read_cmd_t   head;
		job_ctrl_pkg::vertex_job_t job;
		delay = 0;
		forever begin
			next_cycle();
			data_valid = 1'b0;
			// lines go back in grant order after a random gap
			if (delay > 0) begin
				delay--;
			end else if (granted.size() > 0) begin
				head       = granted.pop_front();
				data_valid = 1'b1;
				data_array = head.tag;
				for (int i = 0; i < `CACHELINE_VERTICES; i++)
					data_line[i*`VERTEX_BITS +: `VERTEX_BITS] =
						mem_word(head.address + i * LANE_BYTES);
				delay = {$random(seed)} % 6;
			end
			cmd_grant = 1'b0;
			if (rstn === 1'b1 && cmd_request === 1'b1 &&
				({$random(seed)} % 100) < grant_pct) begin
				cmd_grant   = 1'b1;
				cmd.address = cmd_address;
				cmd.tag     = cmd_array;
				cmd.count   = cmd_count;
				granted.push_back(cmd);
				got_cmds.push_back(cmd);
				if (cmd.tag == graph_pkg::ARRAY_OUT_DEGREE)
					lanes_requested += int'(cmd.count);
			end
			job_request = 1'b0;
			if (rstn === 1'b1 && job_valid === 1'b1 && consume_enable &&
				({$random(seed)} % 100) < consume_pct) begin
				job_request    = 1'b1;
				job.id         = job_id;
				job.out_degree = job_out_degree;
				job.edges_idx  = job_edges_idx;
				job.data       = job_data;
				got_jobs.push_back(job);
				jobs_popped++;
			end
		end
	end

	// half a cycle away from the recorders
	initial begin : compare_results
		job_ctrl_pkg::read_cmd_t   got_cmd;
		job_ctrl_pkg::read_cmd_t   want_cmd;
		job_ctrl_pkg::vertex_job_t got_job;
		job_ctrl_pkg::vertex_job_t want_job;
		forever begin
			@(negedge clock);
			while (got_cmds.size() > 0) begin
				got_cmd = got_cmds.pop_front();
				if (exp_cmds.size() == 0) begin
					report_problem($sformatf("unexpected command for address %h in %s",
						got_cmd.address, test_name));
				end else begin
					want_cmd = exp_cmds.pop_front();
					check_equal($sformatf("%s command %0d", test_name, cmd_index),
						128'(want_cmd), 128'(got_cmd));
				end
				cmd_index++;
			end
			while (got_jobs.size() > 0) begin
				got_job = got_jobs.pop_front();
				if (exp_jobs.size() == 0) begin
					report_problem($sformatf("unexpected job with id %0d in %s",
						got_job.id, test_name));
				end else begin
					want_job = exp_jobs.pop_front();
					check_equal($sformatf("%s job %0d", test_name, job_index),
						128'(want_job), 128'(got_job));
				end
				job_index++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	task automatic wait_busy(input logic level);
		int cycles;
		cycles = 0;
		while (busy !== level && cycles < STEP_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (busy !== level) begin
			timeout_count++;
			$display("timeout: busy never went to %0b in %s", level, test_name);
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while ((exp_cmds.size() > 0 || exp_jobs.size() > 0) && cycles < STEP_LIMIT) begin
			next_cycle();
			cycles++;
			if (busy)
				report_problem($sformatf("busy came back while %s was draining", test_name));
		end
		if (exp_cmds.size() > 0 || exp_jobs.size() > 0) begin
			timeout_count++;
			$display("timeout: %s still misses %0d commands and %0d jobs", test_name,
				exp_cmds.size(), exp_jobs.size());
		end
	endtask

	task automatic run_range(input string name, input int n, input graph_pkg::address_t od,
		input graph_pkg::address_t aux, input graph_pkg::address_t ei, input int pct,
		input bit hold);
		bit seen_job;
		int pending;
		test_name       = name;
		cmd_index       = 0;
		job_index       = 0;
		lanes_requested = 0;
		jobs_popped     = 0;
		grant_pct       = pct;
		consume_enable  = !hold;
		build_expected(n, od, aux, ei);
		num_vertices    = graph_pkg::vertex_count_t'(n);
		out_degree_base = od;
		aux_base        = aux;
		edges_idx_base  = ei;
		start           = 1'b1;
		next_cycle();
		start = 1'b0;
		wait_busy(1'b1);
		if (hold) begin
			// consumer stays off, the walk has to stall on a full job queue
			seen_job = 1'b0;
			repeat (200) begin
				next_cycle();
				if (seen_job && !job_valid)
					report_problem($sformatf("job_valid dropped without a pop in %s", name));
				seen_job = seen_job | job_valid;
			end
			pending = lanes_requested - jobs_popped;
			if (!job_valid || !busy)
				report_problem($sformatf("walk did not stall with jobs held back in %s", name));
			if (pending > `JOB_QUEUE_DEPTH)
				report_problem($sformatf("%0d jobs pending in %s, more than the queue holds",
					pending, name));
			consume_enable = 1'b1;
		end
		wait_busy(1'b0);
		if (lanes_requested != n)
			report_problem($sformatf("busy fell in %s after only %0d of %0d lanes were read",
				name, lanes_requested, n));
		wait_drained();
		repeat (4) next_cycle();
		if (job_valid || cmd_request)
			report_problem($sformatf("extra commands or jobs left over after %s", name));
	endtask

	initial begin : main_sequence
		seed            = 26043;
		error_count     = 0;
		check_count     = 0;
		timeout_count   = 0;
		grant_pct       = 100;
		consume_pct     = 75;
		consume_enable  = 1'b1;
		test_name       = "reset";
		rstn            = 1'b0;
		start           = 1'b0;
		num_vertices    = '0;
		out_degree_base = '0;
		aux_base        = '0;
		edges_idx_base  = '0;
		cmd_grant       = 1'b0;
		data_valid      = 1'b0;
		data_array      = graph_pkg::ARRAY_OUT_DEGREE;
		data_line       = '0;
		job_request     = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		rstn = 1'b1;
		next_cycle();

		run_range("range_20", 20, 32'h1000_0000, 32'h2000_0400, 32'h3000_0800, 100, 1'b0);
		run_range("range_3", 3, 32'h0000_1000, 32'h0000_2020, 32'h0000_3040, 100, 1'b0);
		run_range("range_8", 8, 32'h0004_0000, 32'h0005_0060, 32'h0006_00a0, 100, 1'b0);
		run_range("range_9", 9, 32'h00a0_0020, 32'h00b0_0040, 32'h00c0_0060, 100, 1'b0);
		run_range("grant_gaps", 37, 32'h4000_0000, 32'h5000_01e0, 32'h6000_0300, 30, 1'b0);
		run_range("job_hold", 40, 32'h7000_0100, 32'h7100_0200, 32'h7200_0300, 80, 1'b1);
		// ids start again at zero for a new range
		run_range("restart", 11, 32'h0123_4560, 32'h0234_5680, 32'h0345_67a0, 60, 1'b0);

		$display("checks %0d errors %0d timeouts %0d", check_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/graph_pkg.sv
verilog/job_ctrl_pkg.sv
verilog/unpack_if.sv
verilog/sync_fifo.sv
verilog/vertex_read_sequencer.sv
verilog/vertex_line_store.sv
verilog/vertex_job_control.sv
verif/tb_vertex_job_control.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vertex job fetcher testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_vertex_job_control -o tb_vertex_job_control
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_vertex_job_control > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
